// ==== hw/virtualPhyPkg.sv ====
// Virtual PHY definitions for MDIO frame fields, opcodes, register defaults and debug map
`default_nettype none

package virtualPhyPkg;

    // Clause 22 frame geometry
    localparam int FRAME_BITS = 32;             // ST, OP, PHYAD, REGAD, TA, DATA
    localparam int DATA_BITS  = 16;             // Register payload
    localparam int ADDR_BITS  = 5;              // PHYAD and REGAD width
    localparam int OP_BITS    = 2;              // Opcode width
    localparam int LOG_DEPTH  = 16;             // Debug frame log entries

    typedef logic [FRAME_BITS-1:0] mdioWord;    // Whole frame, bit 31 first on the wire
    typedef logic [DATA_BITS-1:0]  regData;     // One PHY register
    typedef logic [ADDR_BITS-1:0]  phyAddrT;    // PHY address field
    typedef logic [ADDR_BITS-1:0]  regAddrT;    // Register address field
    typedef logic [OP_BITS-1:0]    mdioOp;      // Opcode field

    // MDIO codes
    localparam mdioOp OP_READ    = 2'b10;
    localparam mdioOp OP_WRITE   = 2'b01;
    localparam logic [1:0] ST_PATTERN = 2'b01;  // Clause 22 start

    // Addresses the model answers
    localparam phyAddrT PHY_ADDR_MAIN = 5'd1;   // Ethernet PHY seen by the MAC
    localparam phyAddrT PHY_ADDR_CONV = 5'd8;   // GMII to RGMII converter

    localparam regData CONV_LINK_VALUE = 16'h0040;  // Converter reports 1G link

    // Standard registers of a linked 1G PHY with autoneg done
    localparam regData REG_DEFAULTS [16] = '{
        16'h1040,   // BMCR, 1G, autoneg enabled
        16'h79ad,   // BMSR, link up, autoneg complete
        16'h001c,   // PHY ID 1
        16'hc916,   // PHY ID 2
        16'h09e1,   // Autoneg advertisement
        16'hcde1,   // Link partner ability
        16'h006f,   // Autoneg expansion
        16'h2801,   // Next page transmit
        16'h6001,   // Link partner next page
        16'h0200,   // 1000BASE-T control, full duplex
        16'h7c00,   // 1000BASE-T status
        16'h0000,
        16'h0000,
        16'h0000,   // MMD access control
        16'h0000,   // MMD access data
        16'h2000    // Extended status, 1G full duplex capable
    };

    // Debug read window
    localparam logic [7:0] DBG_LOG_BASE    = 8'hb0;  // b0 to bf, frame log
    localparam logic [7:0] DBG_MASK_ADDR   = 8'hae;  // Write and read masks
    localparam logic [7:0] DBG_STATUS_ADDR = 8'haf;  // Status word

    // Serial engine states
    typedef enum logic [1:0] {
        stIdle,     // Hunting for preamble
        stRecv,     // Shifting frame bits
        stSave      // One cycle to hand off the frame
    } mdioState;

endpackage

`default_nettype wire

// ==== hw/mdioCmdIf.sv ====
// MDIO command interface linking the serial engine, register responder and debug monitor
`timescale 1ns/1ps
`default_nettype none

interface mdioCmdIf;

    // Decoded command, valid for one cycle
    logic                    cmdValid;
    virtualPhyPkg::mdioOp    cmdOp;
    virtualPhyPkg::phyAddrT  cmdPhyAddr;      // Also steady between strobes
    virtualPhyPkg::regAddrT  cmdRegAddr;

    // Reply, combinational from the addresses
    virtualPhyPkg::regData   rspData;
    logic                    rspUnsupported;  // PHY 1 register above 15

    // Frame hand-off
    logic                    frameDone;       // Strobe in save state
    virtualPhyPkg::mdioWord  frameWord;       // Live shift word, complete at frameDone
    logic                    preambleErr;     // Zero seen while hunting

    modport engine (
        output cmdValid, cmdOp, cmdPhyAddr, cmdRegAddr,
        output frameDone, frameWord, preambleErr,
        input  rspData
    );

    modport responder (
        input  cmdPhyAddr, cmdRegAddr,
        output rspData, rspUnsupported
    );

    modport monitor (
        input  cmdValid, cmdOp, cmdPhyAddr, cmdRegAddr,
        input  rspUnsupported,
        input  frameDone, frameWord, preambleErr
    );

endinterface

`default_nettype wire

// ==== hw/mdioFrameSlave.sv ====
// MDIO serial engine, finds the preamble, shifts a Clause 22 frame in and drives read data
`timescale 1ns/1ps
`default_nettype none

module mdioFrameSlave (
    input  logic      mdc,
    input  logic      reset,
    input  logic      mdioO,        // Line level from the MAC
    input  logic      mdioT,        // High when the MAC has released the line
    output logic      mdioI,        // Reply to the MAC
    mdioCmdIf.engine  cmd
);

    virtualPhyPkg::mdioState state;
    logic [4:0]              cnt;          // Preamble ones, then frame bit index
    virtualPhyPkg::mdioWord  frameData;    // Frame as seen on the line
    virtualPhyPkg::regData   replyData;    // MSB is on mdioI
    logic                    doRead;       // Data half comes from our own reply
    logic                    stOk;
    virtualPhyPkg::mdioOp    op;

    // Field decode, addresses settle once bit 18 is in
    assign stOk = (frameData[31:30] == virtualPhyPkg::ST_PATTERN);
    assign op   = frameData[29:28];

    assign mdioI = replyData[15];

    // Command goes out on the second turnaround bit
    assign cmd.cmdValid   = (state == virtualPhyPkg::stRecv) && (cnt == 5'd15);
    assign cmd.cmdOp      = op;
    assign cmd.cmdPhyAddr = frameData[27:23];
    assign cmd.cmdRegAddr = frameData[22:18];

    assign cmd.frameDone  = (state == virtualPhyPkg::stSave);
    assign cmd.frameWord  = frameData;

    // Driven zero while hunting breaks the preamble
    assign cmd.preambleErr = (state == virtualPhyPkg::stIdle) && !mdioT && !mdioO;

    // Control FSM and reply shifter
    always_ff @(posedge mdc) begin
        if (reset) begin
            state     <= virtualPhyPkg::stIdle;
            cnt       <= 5'd0;
            replyData <= '0;
            doRead    <= 1'b0;
        end else begin
            case (state)
                virtualPhyPkg::stIdle: begin
                    replyData <= '0;                // Keep mdioI quiet
                    doRead    <= 1'b0;
                    if (mdioT) begin
                        cnt <= 5'd0;                // Line released, start over
                    end else if (mdioO) begin
                        cnt <= cnt + 5'd1;          // Wraps to 0 for the frame
                        if (cnt == 5'd31) begin
                            state <= virtualPhyPkg::stRecv;
                        end
                    end else begin
                        cnt <= 5'd0;                // Error counted downstream
                    end
                end

                virtualPhyPkg::stRecv: begin
                    cnt <= cnt + 5'd1;
                    if (cmd.cmdValid) begin
                        replyData <= cmd.rspData;   // Loaded for writes too
                        doRead    <= stOk && (op == virtualPhyPkg::OP_READ);
                    end else begin
                        replyData <= {replyData[14:0], 1'b0};  // Next reply bit
                    end
                    if (cnt == 5'd31) begin
                        state <= virtualPhyPkg::stSave;
                    end
                end

                virtualPhyPkg::stSave: begin
                    state <= virtualPhyPkg::stIdle;  // cnt already back at 0
                end

                default: begin
                    state <= virtualPhyPkg::stIdle;
                end
            endcase
        end
    end

    // Frame shift word, bit 31 arrives first so ~cnt is the bit index
    always_ff @(posedge mdc) begin
        if (state == virtualPhyPkg::stRecv) begin
            frameData[~cnt] <= doRead ? mdioI : mdioO;  // Reads log our own reply
        end
    end

endmodule

`default_nettype wire

// ==== hw/phyRegFile.sv ====
// Read-only PHY register responder for the main PHY and the converter PHY
`timescale 1ns/1ps
`default_nettype none

module phyRegFile (
    mdioCmdIf.responder rsp
);

    logic mainHit;      // PHY address 1
    logic convHit;      // PHY address 8
    logic stdReg;       // Register 0 to 15

    assign mainHit = (rsp.cmdPhyAddr == virtualPhyPkg::PHY_ADDR_MAIN);
    assign convHit = (rsp.cmdPhyAddr == virtualPhyPkg::PHY_ADDR_CONV);
    assign stdReg  = !rsp.cmdRegAddr[4];

    // Same answer for reads and writes, engine ignores it on writes
    always_comb begin
        rsp.rspData        = '0;            // Unknown PHYs read as zero
        rsp.rspUnsupported = 1'b0;
        if (mainHit) begin
            if (stdReg) begin
                rsp.rspData = virtualPhyPkg::REG_DEFAULTS[rsp.cmdRegAddr[3:0]];
            end else begin
                rsp.rspUnsupported = 1'b1;  // Vendor page, not modelled
            end
        end else if (convHit) begin
            rsp.rspData = virtualPhyPkg::CONV_LINK_VALUE;  // Any register
        end
    end

endmodule

`default_nettype wire

// ==== hw/debugCapture.sv ====
// Debug capture of MDIO traffic with frame log, access masks, status word and read port
`timescale 1ns/1ps
`default_nettype none

module debugCapture (
    input  logic         mdc,
    input  logic         reset,
    mdioCmdIf.monitor    mon,
    input  logic [15:0]  regRaddr,     // Debug read address
    output logic [31:0]  regRdata      // Debug read data
);

    virtualPhyPkg::mdioWord logBuf [virtualPhyPkg::LOG_DEPTH];  // Circular frame log
    logic [$clog2(virtualPhyPkg::LOG_DEPTH)-1:0] logPtr;         // Next slot

    logic [15:0]            writeMask;    // Standard registers written
    logic [15:0]            readMask;     // Standard registers read
    virtualPhyPkg::regAddrT regNew;       // Last unsupported register
    virtualPhyPkg::phyAddrT lastPhy;
    virtualPhyPkg::regAddrT lastReg;
    virtualPhyPkg::mdioOp   lastOp;
    logic                   lastStOk;
    logic [3:0]             errCnt;       // Preamble errors, wraps
    logic                   logSkip;      // Frame stays out of the log
    logic [31:0]            statusWord;

    // Link polling would flood the log
    assign logSkip = (mon.frameWord[27:23] == virtualPhyPkg::PHY_ADDR_CONV) ||
                     (mon.frameWord[22:18] == 5'd0) ||
                     (mon.frameWord[22:18] == 5'd1);

    always_ff @(posedge mdc) begin
        if (reset) begin
            writeMask <= '0;
            readMask  <= '0;
            regNew    <= '0;
            lastPhy   <= '0;
            lastReg   <= '0;
            lastOp    <= '0;
            lastStOk  <= 1'b0;
            errCnt    <= '0;
            logPtr    <= '0;
            for (int i = 0; i < virtualPhyPkg::LOG_DEPTH; i++) begin
                logBuf[i] <= '0;
            end
        end else begin
            if (mon.cmdValid) begin
                lastPhy  <= mon.cmdPhyAddr;
                lastReg  <= mon.cmdRegAddr;
                lastOp   <= mon.cmdOp;
                lastStOk <= (mon.frameWord[31:30] == virtualPhyPkg::ST_PATTERN);  // ST is in
                if ((mon.cmdPhyAddr == virtualPhyPkg::PHY_ADDR_MAIN) && !mon.cmdRegAddr[4]) begin
                    if (mon.cmdOp == virtualPhyPkg::OP_READ) begin
                        readMask[mon.cmdRegAddr[3:0]] <= 1'b1;
                    end else if (mon.cmdOp == virtualPhyPkg::OP_WRITE) begin
                        writeMask[mon.cmdRegAddr[3:0]] <= 1'b1;
                    end
                end
                if (mon.rspUnsupported) begin
                    regNew <= mon.cmdRegAddr;   // Register the MAC wants but we lack
                end
            end
            if (mon.frameDone && !logSkip) begin
                logBuf[logPtr] <= mon.frameWord;
                logPtr         <= logPtr + 1'b1;  // Overwrites oldest
            end
            if (mon.preambleErr) begin
                errCnt <= errCnt + 4'd1;
            end
        end
    end

    assign statusWord = {3'd0, regNew, 3'd0, lastPhy, 3'd0, lastReg,
                         errCnt, 1'b0, lastStOk, lastOp};

    // Side-effect free read mux, upper address byte must be clear
    always_comb begin
        if (regRaddr[15:4] == {8'd0, virtualPhyPkg::DBG_LOG_BASE[7:4]}) begin
            regRdata = logBuf[regRaddr[3:0]];
        end else if (regRaddr == {8'd0, virtualPhyPkg::DBG_MASK_ADDR}) begin
            regRdata = {writeMask, readMask};
        end else if (regRaddr == {8'd0, virtualPhyPkg::DBG_STATUS_ADDR}) begin
            regRdata = statusWord;
        end else begin
            regRdata = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/virtualPhy.sv ====
// Virtual Ethernet PHY top level answering Clause 22 MDIO with fixed register values
`timescale 1ns/1ps
`default_nettype none

module virtualPhy (
    input  logic         mdc,          // Management clock from the MAC
    input  logic         reset,
    input  logic         mdioO,        // MAC output level
    input  logic         mdioT,        // MAC tristate, high when released
    output logic         mdioI,        // Level returned to the MAC
    input  logic [15:0]  regRaddr,     // Debug read address
    output logic [31:0]  regRdata      // Debug read data
);

    mdioCmdIf cmdBus ();                // Engine to responder and monitor

    // Serial protocol engine
    mdioFrameSlave uFrameSlave (
        .mdc   (mdc),
        .reset (reset),
        .mdioO (mdioO),
        .mdioT (mdioT),
        .mdioI (mdioI),
        .cmd   (cmdBus.engine)
    );

    // Fixed register contents
    phyRegFile uRegFile (
        .rsp (cmdBus.responder)
    );

    // Traffic log and debug port
    debugCapture uDebug (
        .mdc      (mdc),
        .reset    (reset),
        .mon      (cmdBus.monitor),
        .regRaddr (regRaddr),
        .regRdata (regRdata)
    );

endmodule

`default_nettype wire

// ==== sim/virtualPhy_asserts.sv ====
// MDIO engine assertions on command strobe, frame done spacing and idle reply line
`timescale 1ns/1ps
`default_nettype none

module virtualPhy_asserts (
    input logic                    mdc,
    input logic                    reset,
    input logic                    mdioI,
    input logic                    cmdValid,
    input logic                    frameDone,
    input virtualPhyPkg::mdioState state
);

    int failCount = 0;                  // Assertion failures seen so far

    // Strobes belong to different frame phases, no frame done while the reply shifts
    assert property (@(posedge mdc) disable iff (reset) cmdValid |-> !frameDone [*17])
        else begin
            $error("frameDone before the reply finished");
            failCount++;
        end

    // Sixteen reply bits then the save state
    assert property (@(posedge mdc) disable iff (reset) cmdValid |-> ##17 frameDone)
        else begin
            $error("frameDone not 17 edges after cmdValid");
            failCount++;
        end

    assert property (@(posedge mdc) disable iff (reset)
                     (state == virtualPhyPkg::stIdle) |-> !mdioI)
        else begin
            $error("mdioI high while engine idle");
            failCount++;
        end

endmodule

bind mdioFrameSlave virtualPhy_asserts uAsserts (
    .mdc       (mdc),
    .reset     (reset),
    .mdioI     (mdioI),
    .cmdValid  (cmd.cmdValid),
    .frameDone (cmd.frameDone),
    .state     (state)
);

`default_nettype wire

// ==== sim/virtualPhyTb.sv ====
// Virtual PHY testbench driving MDIO frames from a table and checking replies and debug port
`timescale 1ns/1ps
`default_nettype none

module virtualPhyTb;

    localparam int NUM_ENTRIES = 23;         // Rows in the stimulus table
    localparam int NUM_ZEROS   = 7;          // Driven zeros for the error count
    localparam int DONE_LIMIT  = 8;          // Edges allowed for frame done

    logic        mdc;
    logic        reset;
    logic        mdioO;
    logic        mdioT;
    logic        mdioI;
    logic [15:0] regRaddr;
    logic [31:0] regRdata;

    int          checkCount;
    int          errorCount;
    int          timeoutCount;
    integer      seed;

    logic [15:0] regCopy [16];               // Expected standard register values
    logic [1:0]  tblOp   [NUM_ENTRIES];
    logic [4:0]  tblPhy  [NUM_ENTRIES];
    logic [4:0]  tblReg  [NUM_ENTRIES];
    logic [15:0] tblData [NUM_ENTRIES];      // Write data
    logic [15:0] tblExp  [NUM_ENTRIES];      // Expected read reply

    logic [31:0] expLog [16];                // Model of the circular log
    logic [3:0]  expPtr;
    logic [15:0] expReadMask;
    logic [15:0] expWriteMask;
    logic [4:0]  expRegNew;

    virtualPhy u_dut (
        .mdc      (mdc),
        .reset    (reset),
        .mdioO    (mdioO),
        .mdioT    (mdioT),
        .mdioI    (mdioI),
        .regRaddr (regRaddr),
        .regRdata (regRdata)
    );

    always #4 mdc = ~mdc;                    // 8 ns period

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED %s expected %h got %h", name, expected, actual);
        end
    endtask

    // Reply rules per PHY address
    function automatic logic [15:0] replyFor(input logic [4:0] phy, input logic [4:0] regAddr);
        if (phy == 5'd1) begin
            return regAddr[4] ? 16'h0000 : regCopy[regAddr[3:0]];
        end else if (phy == 5'd8) begin
            return 16'h0040;                 // Converter link status
        end
        return 16'h0000;
    endfunction

    task automatic addEntry(input int idx, input logic [1:0] op, input logic [4:0] phy,
                            input logic [4:0] regAddr);
        tblOp[idx]   = op;
        tblPhy[idx]  = phy;
        tblReg[idx]  = regAddr;
        tblData[idx] = 16'($random(seed));   // Only used by writes
        tblExp[idx]  = replyFor(phy, regAddr);
    endtask

    task automatic buildTable();
        regCopy = '{16'h1040, 16'h79ad, 16'h001c, 16'hc916, 16'h09e1, 16'hcde1,
                    16'h006f, 16'h2801, 16'h6001, 16'h0200, 16'h7c00, 16'h0000,
                    16'h0000, 16'h0000, 16'h0000, 16'h2000};
        for (int i = 0; i < 16; i++) begin
            addEntry(i, virtualPhyPkg::OP_READ, 5'd1, 5'(i));  // Every standard register
        end
        addEntry(16, virtualPhyPkg::OP_READ, 5'd8, 5'd16);
        addEntry(17, virtualPhyPkg::OP_READ, 5'd3, 5'd5);       // Unknown PHY
        addEntry(18, virtualPhyPkg::OP_READ, 5'd1, 5'd20);      // Unsupported register
        addEntry(19, virtualPhyPkg::OP_WRITE, 5'd1, 5'd4);
        addEntry(20, virtualPhyPkg::OP_WRITE, 5'd1, 5'd0);      // Kept out of the log
        addEntry(21, virtualPhyPkg::OP_WRITE, 5'd8, 5'd0);
        addEntry(22, virtualPhyPkg::OP_WRITE, 5'd1, 5'd9);      // Last command
    endtask

    // Preamble, frame bits on falling edges, then wait for frame done
    task automatic sendFrame(input logic [1:0] op, input logic [4:0] phy,
                             input logic [4:0] regAddr, input logic [15:0] wdata,
                             output logic [15:0] rdata);
        logic [31:0] word;
        int          waited;
        word  = {2'b01, op, phy, regAddr, 2'b10, wdata};
        rdata = '0;
        for (int i = 0; i < 32; i++) begin
            @(negedge mdc);
            mdioT = 1'b0;
            mdioO = 1'b1;
        end
        for (int b = 31; b >= 0; b--) begin
            @(negedge mdc);
            if ((op == virtualPhyPkg::OP_READ) && (b <= 15)) begin
                mdioT    = 1'b1;             // PHY owns the line
                mdioO    = 1'b1;
                rdata[b] = mdioI;            // Reply bit b is valid now
            end else begin
                mdioO = word[b];
            end
        end
        @(negedge mdc);
        mdioT  = 1'b1;
        mdioO  = 1'b1;
        waited = 0;
        while (!u_dut.cmdBus.frameDone && (waited < DONE_LIMIT)) begin
            @(negedge mdc);
            waited++;
        end
        if (!u_dut.cmdBus.frameDone) begin
            timeoutCount++;
            $display("Frame to PHY %0d register %0d never completed", phy, regAddr);
        end
    endtask

    // Debug port read, sampled one falling edge later
    task automatic readDebug(input logic [15:0] addr, output logic [31:0] data);
        @(negedge mdc);
        regRaddr = addr;
        @(negedge mdc);
        data = regRdata;
    endtask

    task automatic applyReset();
        @(negedge mdc);
        reset = 1'b1;
        repeat (16) @(negedge mdc);
        reset = 1'b0;
    endtask

    initial begin
        logic [15:0] rdata;
        logic [31:0] data;
        logic [31:0] word;
        logic [31:0] status;
        mdc          = 1'b0;
        reset        = 1'b1;
        mdioO        = 1'b1;
        mdioT        = 1'b1;                 // MAC starts released
        regRaddr     = '0;
        checkCount   = 0;
        errorCount   = 0;
        timeoutCount = 0;
        seed         = 32'h86c62e50;
        expPtr       = '0;
        expReadMask  = '0;
        expWriteMask = '0;
        expRegNew    = '0;
        for (int i = 0; i < 16; i++) begin
            expLog[i] = '0;
        end
        buildTable();
        repeat (16) @(negedge mdc);
        reset = 1'b0;
        checkValue("mdioI", 32'd0, {31'd0, mdioI});

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            sendFrame(tblOp[i], tblPhy[i], tblReg[i], tblData[i], rdata);
            if (tblOp[i] == virtualPhyPkg::OP_READ) begin
                checkValue("mdioI", {16'd0, tblExp[i]}, {16'd0, rdata});
            end
            word = {2'b01, tblOp[i], tblPhy[i], tblReg[i], 2'b10,
                    (tblOp[i] == virtualPhyPkg::OP_READ) ? tblExp[i] : tblData[i]};
            if ((tblPhy[i] == 5'd1) && !tblReg[i][4]) begin
                if (tblOp[i] == virtualPhyPkg::OP_READ) begin
                    expReadMask[tblReg[i][3:0]] = 1'b1;
                end else begin
                    expWriteMask[tblReg[i][3:0]] = 1'b1;
                end
            end
            if ((tblPhy[i] == 5'd1) && tblReg[i][4]) begin
                expRegNew = tblReg[i];
            end
            if (!((tblPhy[i] == 5'd8) || (tblReg[i] == 5'd0) || (tblReg[i] == 5'd1))) begin
                expLog[expPtr] = word;       // Oldest slot goes first on wrap
                expPtr++;
            end
        end

        for (int i = 0; i < 16; i++) begin
            readDebug(16'h00b0 + 16'(i), data);
            checkValue("regRdata log", expLog[i], data);
        end
        readDebug(16'h00ae, data);
        checkValue("regRdata masks", {expWriteMask, expReadMask}, data);
        status = {3'd0, expRegNew, 3'd0, tblPhy[NUM_ENTRIES-1], 3'd0, tblReg[NUM_ENTRIES-1],
                  4'd0, 1'b0, 1'b1, tblOp[NUM_ENTRIES-1]};
        readDebug(16'h00af, data);
        checkValue("regRdata status", status, data);
        readDebug(16'h01af, data);               // Status alias with upper byte set
        checkValue("regRdata unmapped", 32'd0, data);

        for (int i = 0; i < NUM_ZEROS; i++) begin
            @(negedge mdc);
            mdioT = 1'b0;                    // Driven zero while hunting
            mdioO = 1'b0;
        end
        @(negedge mdc);
        mdioT = 1'b1;
        mdioO = 1'b1;
        status[7:4] = 4'(NUM_ZEROS);
        readDebug(16'h00af, data);
        checkValue("regRdata status", status, data);

        applyReset();
        readDebug(16'h00ae, data);
        checkValue("regRdata masks", 32'd0, data);
        readDebug(16'h00af, data);
        checkValue("regRdata status", 32'd0, data);
        for (int i = 0; i < 16; i++) begin
            readDebug(16'h00b0 + 16'(i), data);
            checkValue("regRdata log", 32'd0, data);
        end

        $display("checks %0d errors %0d timeouts %0d assertion failures %0d", checkCount,
                 errorCount, timeoutCount, u_dut.uFrameSlave.uAsserts.failCount);
        if ((errorCount == 0) && (timeoutCount == 0) &&
            (u_dut.uFrameSlave.uAsserts.failCount == 0)) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== virtualPhy.f ====
hw/virtualPhyPkg.sv
hw/mdioCmdIf.sv
hw/mdioFrameSlave.sv
hw/phyRegFile.sv
hw/debugCapture.sv
hw/virtualPhy.sv
sim/virtualPhy_asserts.sv
sim/virtualPhyTb.sv
